// ==== common/cache_config.svh ====
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Processor side widths
`define CACHE_ADDR_W   32   // Byte address, control select bit sits above it
`define CACHE_DATA_W   32   // One word per line
`define CACHE_NBYTES   4    // Bytes per word
`define CACHE_BYTE_W   2    // Byte offset inside a word

// Line geometry
`define CACHE_INDEX_W  6    // 64 lines, direct mapped

// Word address minus index
`define CACHE_TAG_W    (`CACHE_ADDR_W - `CACHE_BYTE_W - `CACHE_INDEX_W)

// Control space word address
`define CTRL_ADDR_W    2    // Three counters plus one spare code

`endif

// ==== common/cache_pkg.sv ====
`default_nettype none

`include "cache_config.svh"

package cache_pkg;

   //////////////////////////////////////////////////////////////////////
   // Request records

   // Request as held in the front-end register stage
   typedef struct packed {
      logic [`CACHE_ADDR_W-`CACHE_BYTE_W-1:0] addr;   // Word address
      logic [`CACHE_DATA_W-1:0]               wdata;
      logic [`CACHE_NBYTES-1:0]               wstrb;
      logic                                   write;  // Nonzero strobe seen
   } fe_req_t;

   // Request toward the external memory
   typedef struct packed {
      logic                                   valid;  // Held until mem_ack
      logic                                   write;
      logic [`CACHE_ADDR_W-`CACHE_BYTE_W-1:0] addr;   // Word address
      logic [`CACHE_DATA_W-1:0]               wdata;
      logic [`CACHE_NBYTES-1:0]               wstrb;
   } mem_req_t;

   //////////////////////////////////////////////////////////////////////
   // Encodings

   // Back-end sequencer
   typedef enum logic [1:0] {
      IDLE,        // Waiting for a data request
      READ_WAIT,   // Miss fetch outstanding
      WRITE_WAIT,  // Write-through outstanding
      RESPOND      // Refilled word goes back
   } be_state_e;

   // Statistics counters in the control space
   typedef enum logic [`CTRL_ADDR_W-1:0] {
      READ_HITS   = 2'd0,
      READ_MISSES = 2'd1,
      WRITES      = 2'd2   // Code 3 reads as zero
   } ctrl_reg_e;

endpackage

`default_nettype wire

// ==== cache/front_end.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module front_end
   import cache_pkg::*;
(
   input  wire logic                     clk,
   input  wire logic                     reset,
   // Processor port
   input  wire logic                     req,
   input  wire logic [`CACHE_ADDR_W:0]   addr,   // MSB selects control space
   input  wire logic [`CACHE_DATA_W-1:0] wdata,
   input  wire logic [`CACHE_NBYTES-1:0] wstrb,
   output logic                          ack,
   output logic [`CACHE_DATA_W-1:0]      rdata,
   // Data path
   output logic                          data_req,
   output fe_req_t                       data_req_reg,
   input  wire logic                     data_ack,
   input  wire logic [`CACHE_DATA_W-1:0] data_rdata,
   // Control path
   output logic                          ctrl_req,
   output logic [`CTRL_ADDR_W-1:0]       ctrl_addr,
   output logic                          ctrl_we,
   input  wire logic                     ctrl_ack,
   input  wire logic [`CACHE_DATA_W-1:0] ctrl_rdata
);

   logic    req_valid_q;  // A request sits in the stage
   logic    sel_ctrl_q;   // Held request targets the control space
   fe_req_t req_q;
   logic    accept;

   // Only take a new request once the previous one has been acked
   assign accept = req & ~req_valid_q;

   //////////////////////////////////////////////////////////////////////
   // Registered request stage

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         req_valid_q <= 1'b0;
         sel_ctrl_q  <= 1'b0;
         req_q       <= '0;
      end
      else if (accept)
      begin
         req_valid_q <= 1'b1;
         sel_ctrl_q  <= addr[`CACHE_ADDR_W];
         req_q.addr  <= addr[`CACHE_ADDR_W-1:`CACHE_BYTE_W];  // Drop byte offset
         req_q.wdata <= wdata;
         req_q.wstrb <= wstrb;
         req_q.write <= |wstrb;
      end
      else if (ack)
         req_valid_q <= 1'b0;                               // Stage free again
   end

   //////////////////////////////////////////////////////////////////////
   // Routing and response

   assign data_req     = req_valid_q & ~sel_ctrl_q;
   assign data_req_reg = req_q;

   assign ctrl_req  = req_valid_q & sel_ctrl_q;
   assign ctrl_addr = req_q.addr[`CTRL_ADDR_W-1:0];  // Low word-address bits
   assign ctrl_we   = req_q.write;

   assign ack   = data_ack | ctrl_ack;
   assign rdata = ctrl_ack ? ctrl_rdata : data_rdata;

   // Both paths answering at once would corrupt rdata
   a_one_ack: assert property (@(posedge clk) disable iff (reset)
      !(ctrl_ack && data_ack));

endmodule

`default_nettype wire

// ==== cache/cache_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module cache_memory
   import cache_pkg::*;
(
   input  wire logic                     clk,
   input  wire logic                     reset,
   // Lookup on the registered request
   input  wire logic                     lookup,
   input  wire fe_req_t                  fe_req,
   output logic                          hit,
   output logic [`CACHE_DATA_W-1:0]      hit_rdata,
   // Updates from the back end
   input  wire logic                     refill_we,
   input  wire logic [`CACHE_DATA_W-1:0] refill_data,
   input  wire logic                     wt_update
);

   localparam int NLINES = 1 << `CACHE_INDEX_W;

   //////////////////////////////////////////////////////////////////////
   // Storage

   logic [NLINES-1:0]        valid_q;              // One bit per line
   logic [`CACHE_TAG_W-1:0]  tag_mem  [NLINES];
   logic [`CACHE_DATA_W-1:0] data_mem [NLINES];

   logic [`CACHE_INDEX_W-1:0] idx;
   logic [`CACHE_TAG_W-1:0]   tag;
   logic                      tag_match;
   logic                      wt_en;

   //////////////////////////////////////////////////////////////////////
   // Address split and hit detection

   // Low word-address bits pick the line, the rest is the tag
   assign idx = fe_req.addr[`CACHE_INDEX_W-1:0];
   assign tag = fe_req.addr[`CACHE_INDEX_W +: `CACHE_TAG_W];

   assign tag_match = (tag_mem[idx] == tag);
   assign hit       = lookup & valid_q[idx] & tag_match;
   assign hit_rdata = data_mem[idx];  // Qualified by hit downstream

   // Write miss leaves the arrays alone
   assign wt_en = wt_update & hit;

   //////////////////////////////////////////////////////////////////////
   // Valid bits

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         valid_q <= '0;                 // Cache starts empty
      else if (refill_we)
         valid_q[idx] <= 1'b1;
   end

   //////////////////////////////////////////////////////////////////////
   // Tag and data arrays

   always_ff @(posedge clk)
   begin
      if (refill_we)
      begin
         tag_mem[idx]  <= tag;          // Line now owned by this address
         data_mem[idx] <= refill_data;  // Whole word from memory
      end
      else if (wt_en)
      begin
         // Merge strobed bytes only
         for (int b = 0; b < `CACHE_NBYTES; b++)
         begin
            if (fe_req.wstrb[b])
               data_mem[idx][b*8 +: 8] <= fe_req.wdata[b*8 +: 8];
         end
      end
   end

   // Refill belongs to a read miss, update to a write; never the same request
   a_no_dual_write: assert property (@(posedge clk) disable iff (reset)
      !(refill_we && wt_update));

endmodule

`default_nettype wire

// ==== cache/back_end.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module back_end
   import cache_pkg::*;
(
   input  wire logic                     clk,
   input  wire logic                     reset,
   input  wire logic                     data_req,
   input  wire fe_req_t                  fe_req,
   input  wire logic                     hit,
   input  wire logic [`CACHE_DATA_W-1:0] hit_rdata,
   // External memory
   output mem_req_t                      mem_req,
   input  wire logic [`CACHE_DATA_W-1:0] mem_rdata,
   input  wire logic                     mem_ack,
   // Cache array updates
   output logic                          refill_we,
   output logic [`CACHE_DATA_W-1:0]      refill_data,
   output logic                          wt_update,
   // Response to front end
   output logic                          data_ack,
   output logic [`CACHE_DATA_W-1:0]      data_rdata,
   // Statistics events
   output logic                          ev_read_hit,
   output logic                          ev_read_miss,
   output logic                          ev_write
);

   be_state_e state_q, state_d;
   logic      start;     // New request seen in IDLE
   logic      rd_hit;

   // data_ack blocks a second start while the stage is being released
   assign start  = (state_q == IDLE) & data_req & ~data_ack;
   assign rd_hit = start & ~fe_req.write & hit;

   //////////////////////////////////////////////////////////////////////
   // Sequencer

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         IDLE:
            if (start && fe_req.write)
               state_d = WRITE_WAIT;
            else if (start && !hit)
               state_d = READ_WAIT;            // Read hit stays here
         READ_WAIT:  if (mem_ack) state_d = RESPOND;
         WRITE_WAIT: if (mem_ack) state_d = IDLE;
         RESPOND:    state_d = IDLE;
         default:    state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state_q  <= IDLE;
         data_ack <= 1'b0;
      end
      else
      begin
         state_q  <= state_d;
         data_ack <= rd_hit                                  // Hit answers at once
                   | ((state_q == WRITE_WAIT) & mem_ack)
                   | (state_q == RESPOND);
      end
   end

   always_ff @(posedge clk)
   begin
      if (rd_hit)
         data_rdata <= hit_rdata;
      else if ((state_q == READ_WAIT) && mem_ack)
         data_rdata <= mem_rdata;                          // Fetched word
   end

   //////////////////////////////////////////////////////////////////////
   // Memory request, taken straight from the held front-end request

   always_comb
   begin
      mem_req.valid = (state_q == READ_WAIT) || (state_q == WRITE_WAIT);
      mem_req.write = (state_q == WRITE_WAIT);
      mem_req.addr  = fe_req.addr;
      mem_req.wdata = fe_req.wdata;
      mem_req.wstrb = fe_req.wstrb;
   end

   assign refill_we   = (state_q == READ_WAIT) & mem_ack;
   assign refill_data = mem_rdata;
   assign wt_update   = (state_q == WRITE_WAIT) & mem_ack;  // Gated by hit in the arrays

   // One event per request, all at its start
   assign ev_read_hit  = rd_hit;
   assign ev_read_miss = start & ~fe_req.write & ~hit;
   assign ev_write     = start & fe_req.write;

   // Memory sees a steady request until it acknowledges
   a_mem_stable: assert property (@(posedge clk) disable iff (reset)
      (mem_req.valid && !mem_ack) |=> (mem_req.valid && $stable(mem_req)));

endmodule

`default_nettype wire

// ==== cache/cache_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module cache_control
   import cache_pkg::*;
(
   input  wire logic                   clk,
   input  wire logic                   reset,
   input  wire logic                   ctrl_req,
   input  wire logic [`CTRL_ADDR_W-1:0] ctrl_addr,
   input  wire logic                   ctrl_we,
   input  wire logic                   ev_read_hit,
   input  wire logic                   ev_read_miss,
   input  wire logic                   ev_write,
   output logic                        ctrl_ack,
   output logic [`CACHE_DATA_W-1:0]    ctrl_rdata
);

   localparam int NCNT = 3;

   logic [`CACHE_DATA_W-1:0] cnt_q [NCNT];
   logic [NCNT-1:0]          ev;           // Indexed by ctrl_reg_e code
   logic [`CACHE_DATA_W-1:0] sel_cnt;
   logic                     start;
   logic                     clear;

   assign ev    = {ev_write, ev_read_miss, ev_read_hit};
   assign start = ctrl_req & ~ctrl_ack;    // Once per held request
   assign clear = start & ctrl_we;         // Any control write

   // Saturating statistics counters
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < NCNT; i++)
            cnt_q[i] <= '0;
      end
      else
      begin
         for (int i = 0; i < NCNT; i++)
         begin
            if (clear)
               cnt_q[i] <= '0;
            else if (ev[i] && (cnt_q[i] != '1))
               cnt_q[i] <= cnt_q[i] + 1'b1;   // Stick at all ones
         end
      end
   end

   // Read select
   always_comb
   begin
      case (ctrl_reg_e'(ctrl_addr))
         READ_HITS:   sel_cnt = cnt_q[READ_HITS];
         READ_MISSES: sel_cnt = cnt_q[READ_MISSES];
         WRITES:      sel_cnt = cnt_q[WRITES];
         default:     sel_cnt = '0;          // Spare code
      endcase
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         ctrl_ack <= 1'b0;
      else
         ctrl_ack <= start;                  // One-cycle pulse
   end

   always_ff @(posedge clk)
   begin
      if (start)
         ctrl_rdata <= ctrl_we ? '0 : sel_cnt;
   end

endmodule

`default_nettype wire

// ==== src/cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module cache_top
   import cache_pkg::*;
(
   input  wire logic                     clk,
   input  wire logic                     reset,
   // Processor port
   input  wire logic                     req,
   input  wire logic [`CACHE_ADDR_W:0]   addr,
   input  wire logic [`CACHE_DATA_W-1:0] wdata,
   input  wire logic [`CACHE_NBYTES-1:0] wstrb,
   output logic                          ack,
   output logic [`CACHE_DATA_W-1:0]      rdata,
   // Memory port
   output mem_req_t                      mem_req,
   input  wire logic [`CACHE_DATA_W-1:0] mem_rdata,
   input  wire logic                     mem_ack
);

   // Front end to data path
   logic                     data_req;
   fe_req_t                  data_req_reg;
   logic                     data_ack;
   logic [`CACHE_DATA_W-1:0] data_rdata;
   // Front end to control
   logic                     ctrl_req, ctrl_we, ctrl_ack;
   logic [`CTRL_ADDR_W-1:0]  ctrl_addr;
   logic [`CACHE_DATA_W-1:0] ctrl_rdata;
   // Arrays and back end
   logic                     hit, refill_we, wt_update;
   logic [`CACHE_DATA_W-1:0] hit_rdata, refill_data;
   logic                     ev_read_hit, ev_read_miss, ev_write;

   front_end fe0 (
      .clk, .reset, .req, .addr, .wdata, .wstrb, .ack, .rdata,
      .data_req, .data_req_reg, .data_ack, .data_rdata,
      .ctrl_req, .ctrl_addr, .ctrl_we, .ctrl_ack, .ctrl_rdata
   );

   cache_memory mem0 (
      .clk, .reset,
      .lookup (data_req),
      .fe_req (data_req_reg),
      .hit, .hit_rdata, .refill_we, .refill_data, .wt_update
   );

   back_end be0 (
      .clk, .reset, .data_req,
      .fe_req (data_req_reg),
      .hit, .hit_rdata, .mem_req, .mem_rdata, .mem_ack,
      .refill_we, .refill_data, .wt_update, .data_ack, .data_rdata,
      .ev_read_hit, .ev_read_miss, .ev_write
   );

   cache_control ctrl0 (
      .clk, .reset, .ctrl_req, .ctrl_addr, .ctrl_we,
      .ev_read_hit, .ev_read_miss, .ev_write, .ctrl_ack, .ctrl_rdata
   );

endmodule

`default_nettype wire

// ==== dv/tb_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module tb_mem_model
   import cache_pkg::*;
(
   input  wire logic                     clk,
   input  wire logic                     reset,
   input  wire mem_req_t                 mem_req,
   input  wire logic [3:0]               latency,   // Cycles to mem_ack, 1 to 8
   output logic [`CACHE_DATA_W-1:0]      mem_rdata,
   output logic                          mem_ack
);

   localparam int MEM_AW    = 10;                   // Word window the testbench uses
   localparam int MEM_WORDS = 1 << MEM_AW;

   logic [`CACHE_DATA_W-1:0] mem [MEM_WORDS];      // Shadow of external memory
   logic [MEM_AW-1:0]        idx;
   logic [3:0]               wait_cnt;

   assign idx = mem_req.addr[MEM_AW-1:0];

   // Power-on content, every word-address bit mixed in
   function automatic logic [31:0] fill_word(input logic [29:0] waddr);
      return {waddr[15:0], ~waddr[29:14]} ^ 32'h5a3c_96e1;
   endfunction

   always @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         mem_ack   <= 1'b0;
         mem_rdata <= '0;
         wait_cnt  <= '0;
         for (int i = 0; i < MEM_WORDS; i++)
            mem[i] <= fill_word(30'(i));
      end
      else
      begin
         mem_ack <= 1'b0;                              // One-cycle pulse
         if (mem_req.valid && !mem_ack)
         begin
            if (wait_cnt + 4'd1 >= latency)
            begin
               mem_ack  <= 1'b1;
               wait_cnt <= '0;
               if (mem_req.write)
               begin
                  for (int b = 0; b < `CACHE_NBYTES; b++)
                  begin
                     if (mem_req.wstrb[b])
                        mem[idx][b*8 +: 8] <= mem_req.wdata[b*8 +: 8];
                  end
               end
               else
                  mem_rdata <= mem[idx];
            end
            else
               wait_cnt <= wait_cnt + 4'd1;            // Still stalling
         end
      end
   end

endmodule

`default_nettype wire

// ==== dv/tb_cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module tb_cache_top
   import cache_pkg::*;
();

   localparam int WA_W        = `CACHE_ADDR_W - `CACHE_BYTE_W;  // Word address bits
   localparam int WIN_W       = 10;                             // Word window in use
   localparam int NLINES      = 1 << `CACHE_INDEX_W;
   localparam int TIMEOUT_CYC = 100;

   // What the compare process expects for one request
   typedef struct packed {
      logic [31:0] data;
      logic        chk;     // Compare rdata
      logic [7:0]  lat;     // Exact ack latency or zero when free
      logic [31:0] start;   // Cycle the request was driven
   } expect_t;

   logic                     clk;
   logic                     reset;
   logic                     req;
   logic [`CACHE_ADDR_W:0]   addr;
   logic [`CACHE_DATA_W-1:0] wdata;
   logic [`CACHE_NBYTES-1:0] wstrb;
   logic                     ack;
   logic [`CACHE_DATA_W-1:0] rdata;
   mem_req_t                 mem_req;
   logic [`CACHE_DATA_W-1:0] mem_rdata;
   logic                     mem_ack;
   logic [3:0]               latency;

   logic [31:0] lfsr = 32'h4aad_e664;
   logic [31:0] cyc  = '0;

   // Reference state
   logic [31:0]             shadow_mem   [1 << WIN_W];
   logic                    shadow_valid [NLINES];
   logic [`CACHE_TAG_W-1:0] shadow_tag   [NLINES];
   logic [31:0]             exp_cnt      [4];      // Indexed by ctrl_reg_e code where 3 stays zero
   expect_t                 exp_q  [$];
   string                   name_q [$];

   cache_top dut0 (
      .clk, .reset, .req, .addr, .wdata, .wstrb, .ack, .rdata,
      .mem_req, .mem_rdata, .mem_ack
   );

   tb_mem_model mem_model0 (.clk, .reset, .mem_req, .latency, .mem_rdata, .mem_ack);

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk)
      cyc <= cyc + 32'd1;

   //////////////////////////////////////////////////////////////////////
   // Reference functions

   // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic logic [31:0] pattern_word(input logic [WA_W-1:0] waddr);
      return {waddr[15:0], ~waddr[29:14]} ^ 32'h5a3c_96e1;   // Same as memory power-on
   endfunction

   function automatic logic predict_hit(input logic [WA_W-1:0] waddr);
      return shadow_valid[waddr[`CACHE_INDEX_W-1:0]]
          && (shadow_tag[waddr[`CACHE_INDEX_W-1:0]] == waddr[WA_W-1:`CACHE_INDEX_W]);
   endfunction

   // One data access and the word a read must see
   function automatic logic [31:0] expect_access(input logic write,
      input logic [WA_W-1:0] waddr, input logic [31:0] data, input logic [3:0] strb);
      logic [`CACHE_INDEX_W-1:0] idx;
      idx = waddr[`CACHE_INDEX_W-1:0];
      if (write)
      begin
         exp_cnt[WRITES]++;                   // No allocate and the cached copy follows memory
         for (int b = 0; b < 4; b++)
         begin
            if (strb[b])
               shadow_mem[waddr[WIN_W-1:0]][b*8 +: 8] = data[b*8 +: 8];
         end
      end
      else if (predict_hit(waddr))
         exp_cnt[READ_HITS]++;
      else
      begin
         exp_cnt[READ_MISSES]++;
         shadow_valid[idx] = 1'b1;            // Miss takes the line
         shadow_tag[idx]   = waddr[WA_W-1:`CACHE_INDEX_W];
      end
      return shadow_mem[waddr[WIN_W-1:0]];
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Checking and request tasks

   task automatic stop_on_failure(input string msg);
      $display("%s", msg);
      $display("CHECKS FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      if (exp !== act)
         stop_on_failure($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
   endtask

   // Compares every response against the oldest expectation
   always @(negedge clk)
   begin
      expect_t e;
      string   name;
      if (!reset && ack)
      begin
         if (exp_q.size() == 0)
            stop_on_failure("Acknowledge seen with no request outstanding");
         else
         begin
            e    = exp_q.pop_front();
            name = name_q.pop_front();
            if (e.chk)
               check_value(name, e.data, rdata);
            if (e.lat != 0)
               check_value({name, " latency"}, 32'(e.lat), cyc - e.start);
         end
      end
   end

   task automatic issue_request(input string name, input logic ctrl,
      input logic [WA_W-1:0] waddr, input logic [31:0] data, input logic [3:0] strb,
      input logic [31:0] exp, input logic chk, input int lat);
      int waited;
      @(negedge clk);
      latency = 4'd1 + 4'(rand_bits(3));      // Fresh memory stall per request
      req     = 1'b1;
      addr    = {ctrl, waddr, 2'b00};
      wdata   = data;
      wstrb   = strb;
      exp_q.push_back('{data: exp, chk: chk, lat: 8'(lat), start: cyc});
      name_q.push_back(name);
      waited = 0;
      do
      begin
         @(negedge clk);
         waited++;
         if (waited > TIMEOUT_CYC)
            stop_on_failure({"No acknowledge for request ", name});
      end
      while (!ack);
      req   = 1'b0;                           // Drop in the ack cycle
      wstrb = '0;
   endtask

   task automatic write_word(input string name, input logic [WA_W-1:0] waddr,
                             input logic [31:0] data, input logic [3:0] strb);
      void'(expect_access(1'b1, waddr, data, strb));
      issue_request(name, 1'b0, waddr, data, strb, '0, 1'b0, 0);
   endtask

   task automatic read_word(input string name, input logic [WA_W-1:0] waddr);
      int          lat;
      logic [31:0] exp;
      lat = predict_hit(waddr) ? 2 : 0;       // Only hits have a fixed latency
      exp = expect_access(1'b0, waddr, '0, '0);
      issue_request(name, 1'b0, waddr, '0, '0, exp, 1'b1, lat);
   endtask

   task automatic check_counters(input string stage);
      for (int c = 0; c < 4; c++)
         issue_request($sformatf("%s counter %0d", stage, c), 1'b1, WA_W'(c), '0, '0,
                       exp_cnt[c], 1'b1, 2);
   endtask

   task automatic clear_counters();
      for (int c = 0; c < 4; c++)
         exp_cnt[c] = '0;
      issue_request("counter clear", 1'b1, '0, 32'hffff_ffff, 4'hf, '0, 1'b0, 2);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence

   initial
   begin
      logic [WA_W-1:0] waddr_list [16];
      logic [WA_W-1:0] a;
      logic [WA_W-1:0] b;
      logic [3:0]      strb;
      reset   = 1'b1;
      req     = 1'b0;
      addr    = '0;
      wdata   = '0;
      wstrb   = '0;
      latency = 4'd1;
      for (int i = 0; i < (1 << WIN_W); i++)
         shadow_mem[i] = pattern_word(WA_W'(i));
      for (int i = 0; i < NLINES; i++)
      begin
         shadow_valid[i] = 1'b0;
         shadow_tag[i]   = '0;
      end
      for (int c = 0; c < 4; c++)
         exp_cnt[c] = '0;
      repeat (10) @(negedge clk);
      reset = 1'b0;

      // Quiet after reset
      repeat (5)
      begin
         @(negedge clk);
         check_value("idle ack", '0, 32'(ack));
         check_value("idle mem_req valid", '0, 32'(mem_req.valid));
      end
      check_counters("reset");

      // Write then read back twice so the second read hits
      for (int i = 0; i < 16; i++)
      begin
         waddr_list[i] = WA_W'(rand_bits(WIN_W));
         write_word("random write", waddr_list[i], rand_bits(32), 4'hf);
      end
      for (int i = 0; i < 16; i++)
      begin
         read_word("readback", waddr_list[i]);
         read_word("readback hit", waddr_list[i]);
      end

      // Byte strobes on a cached line and on a write miss
      a = WA_W'(rand_bits(WIN_W));
      b = a ^ (WA_W'(1) << `CACHE_INDEX_W);   // Same line with another tag
      read_word("strobe line fill", a);
      write_word("strobe hit write", a, 32'hdead_beef, 4'b0101);
      check_value("strobe hit memory", shadow_mem[a[WIN_W-1:0]], mem_model0.mem[a[WIN_W-1:0]]);
      read_word("strobe hit read", a);
      write_word("strobe miss write", b, 32'h1234_5678, 4'b1010);
      check_value("strobe miss memory", shadow_mem[b[WIN_W-1:0]], mem_model0.mem[b[WIN_W-1:0]]);
      read_word("strobe miss read", b);

      // Ping-pong eviction on one index
      a = WA_W'(rand_bits(WIN_W));
      b = a ^ (WA_W'(2) << `CACHE_INDEX_W);
      repeat (3)
      begin
         read_word("evict a", a);
         read_word("evict b", b);
      end
      check_counters("eviction");

      // Random mix over a narrow window for many hits
      clear_counters();
      for (int i = 0; i < 200; i++)
      begin
         a = WA_W'(rand_bits(7));
         if (rand_bits(2) == 32'd0)
         begin
            strb = 4'(rand_bits(4));
            if (strb == '0)
               strb = 4'b0001;                // Zero strobe would be a read
            write_word("mix write", a, rand_bits(32), strb);
         end
         else
            read_word("mix read", a);
      end
      check_counters("mix");
      clear_counters();
      check_counters("after clear");

      // Quiet again once the last request is done
      repeat (5)
      begin
         @(negedge clk);
         check_value("final idle ack", '0, 32'(ack));
      end
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+common
common/cache_pkg.sv
cache/front_end.sv
cache/cache_memory.sv
cache/back_end.sv
cache/cache_control.sv
src/cache_top.sv
dv/tb_mem_model.sv
dv/tb_cache_top.sv

// ==== Bender.yml ====
package:
  name: cache

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cache_pkg.sv
      - cache/front_end.sv
      - cache/cache_memory.sv
      - cache/back_end.sv
      - cache/cache_control.sv
      - src/cache_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/tb_mem_model.sv
      - dv/tb_cache_top.sv
